/* hw/sprite_io_pkg.sv */
//**************************************************
// Register map and widths for the sprite I/O slave
// Word index is taken from address bits 5 to 2
// Narrow registers read back zero-extended
//**************************************************

package sprite_io_pkg;

   //**************************************************
   // Widths
   //**************************************************

   // Wishbone data word and slave byte address
   typedef logic [31:0] wb_dat_t;
   typedef logic [5:0]  wb_adr_t;

   typedef logic [3:0]  reg_idx_t;

   // Up, down, left, right, centre from bit 4 down
   typedef logic [4:0]  btn_t;

   // Enough for 640x480
   typedef logic [9:0]  coord_t;

   typedef logic [15:0] gpio_t;

   //**************************************************
   // Register map
   //**************************************************

   localparam reg_idx_t REG_BTN      = 4'd0;
   localparam reg_idx_t REG_ROW      = 4'd1;
   localparam reg_idx_t REG_COL      = 4'd2;
   localparam reg_idx_t REG_SCRATCH  = 4'd3;
   localparam reg_idx_t REG_GPIO_OUT = 4'd4;
   localparam reg_idx_t REG_GPIO_OE  = 4'd5;
   localparam reg_idx_t REG_GPIO_IN  = 4'd6;

   // Reset values and synchronizer depth
   localparam coord_t SPRITE_RESET_POS = 10'd100;
   localparam int     SYNC_STAGES      = 2;

endpackage

/* hw/wb_slave_port.sv */
//**************************************************
// Wishbone classic slave front end
// One wait state per access, ack lasts one cycle
// Master must hold adr, dat, we, cyc, stb until ack
// Index is passed through, never decoded here
//**************************************************

`timescale 1ns/10ps

module wb_slave_port (
   input  logic                    clk,
   input  logic                    wb_rst,
   // Bus master side
   input  sprite_io_pkg::wb_adr_t  i_wb_adr,
   input  sprite_io_pkg::wb_dat_t  i_wb_dat,
   input  logic                    i_wb_we,
   input  logic                    i_wb_cyc,
   input  logic                    i_wb_stb,
   output sprite_io_pkg::wb_dat_t  o_wb_rdt,
   output logic                    o_wb_ack,
   // Register bank side
   output logic                    o_wr_en,
   output sprite_io_pkg::reg_idx_t o_idx,
   output sprite_io_pkg::wb_dat_t  o_wdat,
   input  sprite_io_pkg::wb_dat_t  i_sprite_rdat,
   input  sprite_io_pkg::wb_dat_t  i_gpio_rdat
);

   import sprite_io_pkg::*;

   logic ack_ff;
   logic req;

   // New request seen while no ack is out
   assign req = i_wb_cyc & i_wb_stb & ~ack_ff;

   //**************************************************
   // Handshake
   //**************************************************

   // Ack drops after one cycle even if stb stays high
   always_ff @(posedge clk or posedge wb_rst) begin
      if (wb_rst) begin
         ack_ff <= 1'b0;
      end else begin
         ack_ff <= req;
      end
   end

   assign o_wb_ack = ack_ff;

   // Banks update on the edge that raises ack
   assign o_wr_en = req & i_wb_we;
   assign o_idx   = i_wb_adr[5:2];
   assign o_wdat  = i_wb_dat;

   //**************************************************
   // Read data
   //**************************************************

   // Banks return zero outside their own range
   always_ff @(posedge clk) begin
      if (req) begin
         o_wb_rdt <= i_sprite_rdat | i_gpio_rdat;
      end
   end

   // Back-to-back requests still get a gap between acks
   a_ack_single : assert property (@(posedge clk) disable iff (wb_rst)
      o_wb_ack |=> !o_wb_ack);

   // No ack without a request on the previous cycle
   a_ack_after_req : assert property (@(posedge clk) disable iff (wb_rst)
      o_wb_ack |-> $past(i_wb_cyc && i_wb_stb));

endmodule

/* hw/sprite_regs.sv */
//**************************************************
// Button input and sprite position registers
// Indices 0 to 3, other indices read as zero
// Buttons pass a 2-flop synchronizer before read
// Row and column come out of reset at 100
//**************************************************

`timescale 1ns/10ps

module sprite_regs (
   input  logic                    clk,
   input  logic                    wb_rst,
   // From the bus port
   input  logic                    i_wr_en,
   input  sprite_io_pkg::reg_idx_t i_idx,
   input  sprite_io_pkg::wb_dat_t  i_wdat,
   output sprite_io_pkg::wb_dat_t  o_rdat,
   // Board side
   input  sprite_io_pkg::btn_t     i_btn,
   output sprite_io_pkg::coord_t   o_sprite_row,
   output sprite_io_pkg::coord_t   o_sprite_col
);

   import sprite_io_pkg::*;

   btn_t [SYNC_STAGES-1:0] btn_sync;
   coord_t                 row_q;
   coord_t                 col_q;
   wb_dat_t                scratch_q;

   //**************************************************
   // Button synchronizer
   //**************************************************

   always_ff @(posedge clk or posedge wb_rst) begin
      if (wb_rst) begin
         btn_sync <= '0;
      end else begin
         btn_sync[0] <= i_btn;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            btn_sync[i] <= btn_sync[i-1];
         end
      end
   end

   //**************************************************
   // Writable registers
   //**************************************************

   // Sprite position, low bits of the data word
   always_ff @(posedge clk or posedge wb_rst) begin
      if (wb_rst) begin
         row_q <= SPRITE_RESET_POS;
         col_q <= SPRITE_RESET_POS;
      end else if (i_wr_en) begin
         if (i_idx == REG_ROW) begin
            row_q <= i_wdat[$bits(coord_t)-1:0];
         end
         if (i_idx == REG_COL) begin
            col_q <= i_wdat[$bits(coord_t)-1:0];
         end
      end
   end

   // Scratch word for software use
   always_ff @(posedge clk or posedge wb_rst) begin
      if (wb_rst) begin
         scratch_q <= '0;
      end else if (i_wr_en && (i_idx == REG_SCRATCH)) begin
         scratch_q <= i_wdat;
      end
   end

   assign o_sprite_row = row_q;
   assign o_sprite_col = col_q;

   //**************************************************
   // Read-back
   //**************************************************

   always_comb begin
      case (i_idx)
         REG_BTN:     o_rdat = wb_dat_t'(btn_sync[SYNC_STAGES-1]);
         REG_ROW:     o_rdat = wb_dat_t'(row_q);
         REG_COL:     o_rdat = wb_dat_t'(col_q);
         REG_SCRATCH: o_rdat = scratch_q;
         // Not ours, let the other bank answer
         default:     o_rdat = '0;
      endcase
   end

   // VGA side must never see an unknown position
   a_pos_known : assert property (@(posedge clk) disable iff (wb_rst)
      !$isunknown({o_sprite_row, o_sprite_col}));

endmodule

/* hw/gpio_bank.sv */
//**************************************************
// 16-pin GPIO bank, indices 4 to 6
// Pads leave as separate out, enable and in ports
// Pad read goes through a 2-flop synchronizer
//**************************************************

`timescale 1ns/10ps

module gpio_bank (
   input  logic                    clk,
   input  logic                    wb_rst,
   // From the bus port
   input  logic                    i_wr_en,
   input  sprite_io_pkg::reg_idx_t i_idx,
   input  sprite_io_pkg::wb_dat_t  i_wdat,
   output sprite_io_pkg::wb_dat_t  o_rdat,
   // Pad side
   input  sprite_io_pkg::gpio_t    i_gpio_in,
   output sprite_io_pkg::gpio_t    o_gpio_out,
   output sprite_io_pkg::gpio_t    o_gpio_oe
);

   import sprite_io_pkg::*;

   gpio_t [SYNC_STAGES-1:0] pad_sync;
   gpio_t                   out_q;
   gpio_t                   oe_q;

   //**************************************************
   // Output data and enable
   //**************************************************

   // All pins come up as inputs
   always_ff @(posedge clk or posedge wb_rst) begin
      if (wb_rst) begin
         out_q <= '0;
         oe_q  <= '0;
      end else if (i_wr_en) begin
         if (i_idx == REG_GPIO_OUT) begin
            out_q <= i_wdat[$bits(gpio_t)-1:0];
         end
         if (i_idx == REG_GPIO_OE) begin
            oe_q <= i_wdat[$bits(gpio_t)-1:0];
         end
      end
   end

   assign o_gpio_out = out_q;
   assign o_gpio_oe  = oe_q;

   //**************************************************
   // Pad input synchronizer
   //**************************************************

   always_ff @(posedge clk or posedge wb_rst) begin
      if (wb_rst) begin
         pad_sync <= '0;
      end else begin
         pad_sync[0] <= i_gpio_in;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            pad_sync[i] <= pad_sync[i-1];
         end
      end
   end

   // Read-back, zero outside our indices
   always_comb begin
      case (i_idx)
         REG_GPIO_OUT: o_rdat = wb_dat_t'(out_q);
         REG_GPIO_OE:  o_rdat = wb_dat_t'(oe_q);
         REG_GPIO_IN:  o_rdat = wb_dat_t'(pad_sync[SYNC_STAGES-1]);
         default:      o_rdat = '0;
      endcase
   end

   // Pins must not drive while the board is in reset
   a_oe_reset : assert property (@(posedge clk)
      wb_rst |-> (o_gpio_oe == '0));

endmodule

/* hw/sprite_io_top.sv */
//**************************************************
// Sprite I/O slave top level
// Wishbone classic, one access in flight, 2 cycles
// No sel, err or retry, only full-word accesses
//**************************************************

`timescale 1ns/10ps

module sprite_io_top (
   input  logic                   clk,
   input  logic                   wb_rst,
   // Wishbone classic slave
   input  sprite_io_pkg::wb_adr_t i_wb_adr,
   input  sprite_io_pkg::wb_dat_t i_wb_dat,
   input  logic                   i_wb_we,
   input  logic                   i_wb_cyc,
   input  logic                   i_wb_stb,
   output sprite_io_pkg::wb_dat_t o_wb_rdt,
   output logic                   o_wb_ack,
   // Buttons and VGA sprite position
   input  sprite_io_pkg::btn_t    i_btn,
   output sprite_io_pkg::coord_t  o_sprite_row,
   output sprite_io_pkg::coord_t  o_sprite_col,
   // GPIO pads
   input  sprite_io_pkg::gpio_t   i_gpio_in,
   output sprite_io_pkg::gpio_t   o_gpio_out,
   output sprite_io_pkg::gpio_t   o_gpio_oe
);

   import sprite_io_pkg::*;

   // Shared register bus to both banks
   logic     wr_en;
   reg_idx_t idx;
   wb_dat_t  wdat;

   // Read data back from each bank
   wb_dat_t  sprite_rdat;
   wb_dat_t  gpio_rdat;

   //**************************************************
   // Bus front end
   //**************************************************

   wb_slave_port u_port (
      .clk           (clk),
      .wb_rst        (wb_rst),
      .i_wb_adr      (i_wb_adr),
      .i_wb_dat      (i_wb_dat),
      .i_wb_we       (i_wb_we),
      .i_wb_cyc      (i_wb_cyc),
      .i_wb_stb      (i_wb_stb),
      .o_wb_rdt      (o_wb_rdt),
      .o_wb_ack      (o_wb_ack),
      .o_wr_en       (wr_en),
      .o_idx         (idx),
      .o_wdat        (wdat),
      .i_sprite_rdat (sprite_rdat),
      .i_gpio_rdat   (gpio_rdat)
   );

   //**************************************************
   // Register banks
   //**************************************************

   sprite_regs u_sprite (
      .clk          (clk),
      .wb_rst       (wb_rst),
      .i_wr_en      (wr_en),
      .i_idx        (idx),
      .i_wdat       (wdat),
      .o_rdat       (sprite_rdat),
      .i_btn        (i_btn),
      .o_sprite_row (o_sprite_row),
      .o_sprite_col (o_sprite_col)
   );

   gpio_bank u_gpio (
      .clk        (clk),
      .wb_rst     (wb_rst),
      .i_wr_en    (wr_en),
      .i_idx      (idx),
      .i_wdat     (wdat),
      .o_rdat     (gpio_rdat),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe)
   );

endmodule

/* dv/tb_tasks.svh */
//**************************************************
// Bus access and compare tasks for the testbench
// Outputs are sampled on the falling clock edge
//**************************************************

task automatic compare_dat(input string name, input wb_dat_t got, input wb_dat_t exp);
   if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      fail_run();
   end
endtask

task automatic compare_coord(input string name, input coord_t got, input coord_t exp);
   if (got !== exp) begin
      $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
      fail_run();
   end
endtask

task automatic compare_gpio(input string name, input gpio_t got, input gpio_t exp);
   if (got !== exp) begin
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      fail_run();
   end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
      fail_run();
   end
endtask

// One access held until ack before the bus is released
task automatic bus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                          output wb_dat_t rdat);
   int waited;
   waited = 0;
   @(posedge clk);
   wb_adr <= adr;
   wb_dat <= dat;
   wb_we  <= we;
   wb_cyc <= 1'b1;
   wb_stb <= 1'b1;
   do begin
      @(negedge clk);
      waited++;
   end while (wb_ack !== 1'b1 && waited < 8);
   if (wb_ack !== 1'b1) begin
      $display("ERROR at %0t: no ack within %0d cycles of a request", $time, waited);
      fail_run();
   end
   if (waited != 2) begin
      $display("ERROR at %0t: ack came %0d cycles after the request, not 1", $time, waited - 1);
      fail_run();
   end
   rdat = wb_rdt;
   @(posedge clk);
   wb_cyc <= 1'b0;
   wb_stb <= 1'b0;
   wb_we  <= 1'b0;
   @(negedge clk);
   compare_flag("o_wb_ack", wb_ack, 1'b0);
endtask

/* dv/tb_sprite_io.sv */
//**************************************************
// Testbench for the sprite I/O Wishbone slave
// Random accesses from a fixed seed are checked
// against a register model
// The run stops at the first error
//**************************************************

`timescale 1ns/10ps

module tb_sprite_io;

   import sprite_io_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 4;
   localparam int NUM_WR       = 200;
   localparam int NUM_IN       = 50;
   localparam int NUM_B2B      = 40;
   localparam int NUM_OPS      = 5 + 2 * NUM_WR + 3 * NUM_IN + NUM_B2B;
   localparam int TIMEOUT_NS   = NUM_OPS * 10 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

   logic    clk;
   logic    wb_rst;
   wb_adr_t wb_adr;
   wb_dat_t wb_dat;
   logic    wb_we;
   logic    wb_cyc;
   logic    wb_stb;
   wb_dat_t wb_rdt;
   logic    wb_ack;
   btn_t    btn;
   coord_t  sprite_row;
   coord_t  sprite_col;
   gpio_t   gpio_in;
   gpio_t   gpio_out;
   gpio_t   gpio_oe;

   int      seed;
   // Expected register contents by word index
   wb_dat_t model [16];
   btn_t    btn_val;
   gpio_t   pad_val;

   sprite_io_top i_dut (
      .clk          (clk),
      .wb_rst       (wb_rst),
      .i_wb_adr     (wb_adr),
      .i_wb_dat     (wb_dat),
      .i_wb_we      (wb_we),
      .i_wb_cyc     (wb_cyc),
      .i_wb_stb     (wb_stb),
      .o_wb_rdt     (wb_rdt),
      .o_wb_ack     (wb_ack),
      .i_btn        (btn),
      .o_sprite_row (sprite_row),
      .o_sprite_col (sprite_col),
      .i_gpio_in    (gpio_in),
      .o_gpio_out   (gpio_out),
      .o_gpio_oe    (gpio_oe)
   );

   task automatic fail_run();
      $display("TEST FAIL");
      $fatal(1, "Simulation stopped on error");
   endtask

   `include "tb_tasks.svh"

   //**************************************************
   // Register model
   //**************************************************

   function automatic wb_dat_t expected_read(reg_idx_t idx);
      case (idx)
         REG_BTN:     return {27'd0, btn_val};
         REG_GPIO_IN: return {16'd0, pad_val};
         default:     return model[idx];
      endcase
   endfunction

   // Writes keep the low bits of narrow registers and skip read-only ones
   function automatic void model_write(reg_idx_t idx, wb_dat_t dat);
      case (idx)
         REG_ROW, REG_COL:          model[idx] = {22'd0, dat[9:0]};
         REG_SCRATCH:               model[idx] = dat;
         REG_GPIO_OUT, REG_GPIO_OE: model[idx] = {16'd0, dat[15:0]};
         default:                   ;
      endcase
   endfunction

   task automatic check_outputs();
      compare_coord("o_sprite_row", sprite_row, model[REG_ROW][9:0]);
      compare_coord("o_sprite_col", sprite_col, model[REG_COL][9:0]);
      compare_gpio("o_gpio_out", gpio_out, model[REG_GPIO_OUT][15:0]);
      compare_gpio("o_gpio_oe", gpio_oe, model[REG_GPIO_OE][15:0]);
   endtask

   // Requests with stb held high from one to the next
   task automatic back_to_back(int count);
      wb_dat_t rnd;
      wb_dat_t dat;
      @(posedge clk);
      for (int k = 0; k < count; k++) begin
         rnd = $random(seed);
         dat = $random(seed);
         wb_adr <= rnd[5:0];
         wb_dat <= dat;
         wb_we  <= rnd[31];
         wb_cyc <= 1'b1;
         wb_stb <= 1'b1;
         @(negedge clk);
         compare_flag("o_wb_ack", wb_ack, 1'b0);
         @(negedge clk);
         compare_flag("o_wb_ack", wb_ack, 1'b1);
         if (rnd[31]) begin
            model_write(rnd[5:2], dat);
            check_outputs();
         end else begin
            compare_dat("o_wb_rdt", wb_rdt, expected_read(rnd[5:2]));
         end
         @(posedge clk);
      end
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      @(negedge clk);
      compare_flag("o_wb_ack", wb_ack, 1'b0);
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   initial begin
      #(TIMEOUT_NS);
      $display("ERROR: run hung, not finished after %0d ns", TIMEOUT_NS);
      fail_run();
   end

   //**************************************************
   // Stimulus
   //**************************************************

   initial begin
      wb_dat_t rnd;
      wb_dat_t wdat;
      wb_dat_t rdat;
      seed        = 32'h1318_d6d4;
      wb_rst      = 1'b1;
      wb_adr      = '0;
      wb_dat      = '0;
      wb_we       = 1'b0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      btn         = '0;
      gpio_in     = '0;
      btn_val     = '0;
      pad_val     = '0;
      for (int i = 0; i < 16; i++) begin
         model[i] = '0;
      end
      model[REG_ROW] = 32'd100;
      model[REG_COL] = 32'd100;
      repeat (RESET_CYCLES) @(posedge clk);
      wb_rst <= 1'b0;
      @(negedge clk);
      compare_flag("o_wb_ack", wb_ack, 1'b0);

      // Reset values
      check_outputs();
      for (int i = 1; i <= 5; i++) begin
         bus_access(1'b0, {reg_idx_t'(i), 2'b00}, '0, rdat);
         compare_dat("o_wb_rdt", rdat, expected_read(reg_idx_t'(i)));
      end

      // Random writes over the whole index range and their read-back
      for (int n = 0; n < NUM_WR; n++) begin
         rnd  = $random(seed);
         wdat = $random(seed);
         bus_access(1'b1, rnd[5:0], wdat, rdat);
         model_write(rnd[5:2], wdat);
         check_outputs();
         bus_access(1'b0, rnd[5:0], '0, rdat);
         compare_dat("o_wb_rdt", rdat, expected_read(rnd[5:2]));
      end

      // Buttons and pads held past the synchronizer delay
      for (int n = 0; n < NUM_IN; n++) begin
         rnd = $random(seed);
         @(posedge clk);
         btn     <= rnd[4:0];
         gpio_in <= rnd[20:5];
         btn_val = rnd[4:0];
         pad_val = rnd[20:5];
         repeat (3) @(posedge clk);
         bus_access(1'b0, {REG_BTN, 2'b00}, '0, rdat);
         compare_dat("o_wb_rdt", rdat, expected_read(REG_BTN));
         bus_access(1'b0, {REG_GPIO_IN, 2'b00}, '0, rdat);
         compare_dat("o_wb_rdt", rdat, expected_read(REG_GPIO_IN));
      end

      back_to_back(NUM_B2B);

      $display("TEST PASS");
      $finish;
   end

endmodule

/* sim.f */
+incdir+dv
hw/sprite_io_pkg.sv
hw/wb_slave_port.sv
hw/sprite_regs.sv
hw/gpio_bank.sv
hw/sprite_io_top.sv
dv/tb_sprite_io.sv

/* Makefile */
# Verilator build and run for the sprite I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_sprite_io
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard dv/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o V$(TOP)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
